// File: hdl/iw_pkg.sv
`default_nettype none

package iw_pkg;

  // ID widths on the slave and the master side of the converter
  localparam int unsigned SLV_ID_W = 6;
  localparam int unsigned MST_ID_W = 2;
  // Every master ID owns exactly one remap table entry
  localparam int unsigned NUM_MST_IDS = 2 ** MST_ID_W;
  // Cap on transactions in flight that share one ID
  localparam int unsigned MAX_TXNS_PER_ID = 4;
  localparam int unsigned TXN_CNT_W = $clog2(MAX_TXNS_PER_ID + 1);
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  // Width of the saturating stall counters in the control
  localparam int unsigned STALL_CNT_W = 16;

  typedef logic [SLV_ID_W-1:0]    slv_id_t;
  typedef logic [MST_ID_W-1:0]    mst_id_t;
  typedef logic [TXN_CNT_W-1:0]   txn_cnt_t;
  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [DATA_W/8-1:0]    strb_t;
  typedef logic [7:0]             len_t;
  typedef logic [1:0]             resp_t;
  typedef logic [STALL_CNT_W-1:0] stall_cnt_t;

  // Address channel payload, shared by AR and AW
  typedef struct packed {slv_id_t id; addr_t addr; len_t len;} slv_ax_t;
  typedef struct packed {mst_id_t id; addr_t addr; len_t len;} mst_ax_t;

  // W carries no ID, so both ports use the same type
  typedef struct packed {data_t data; strb_t strb; logic last;} w_chan_t;

  typedef struct packed {slv_id_t id; resp_t resp;} slv_b_t;
  typedef struct packed {mst_id_t id; resp_t resp;} mst_b_t;

  typedef struct packed {slv_id_t id; data_t data; resp_t resp; logic last;} slv_r_t;
  typedef struct packed {mst_id_t id; data_t data; resp_t resp; logic last;} mst_r_t;

  // Request bundles, driven by the side that issues transactions
  typedef struct packed {
    slv_ax_t aw;
    logic    aw_valid;
    w_chan_t w;
    logic    w_valid;
    logic    b_ready;
    slv_ax_t ar;
    logic    ar_valid;
    logic    r_ready;
  } slv_req_t;

  typedef struct packed {
    mst_ax_t aw;
    logic    aw_valid;
    w_chan_t w;
    logic    w_valid;
    logic    b_ready;
    mst_ax_t ar;
    logic    ar_valid;
    logic    r_ready;
  } mst_req_t;

  // Response bundles, driven by the side that answers transactions
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    slv_b_t  b;
    logic    b_valid;
    logic    ar_ready;
    slv_r_t  r;
    logic    r_valid;
  } slv_rsp_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    mst_b_t  b;
    logic    b_valid;
    logic    ar_ready;
    mst_r_t  r;
    logic    r_valid;
  } mst_rsp_t;

endpackage

`default_nettype wire

// File: hdl/id_remap_table.sv
`timescale 1ns/1ps
`default_nettype none

module id_remap_table (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  iw_pkg::slv_id_t lookup_id_i,
  output logic            match_o,
  output iw_pkg::mst_id_t match_idx_o,
  output logic            match_full_o,
  output logic            free_o,
  output iw_pkg::mst_id_t free_idx_o,
  input  logic            alloc_i,
  input  iw_pkg::mst_id_t alloc_idx_i,
  input  logic            release_i,
  input  iw_pkg::mst_id_t release_idx_i,
  output iw_pkg::slv_id_t orig_id_o
);

  import iw_pkg::*;

  // Owning slave ID and in-flight count of every master ID
  slv_id_t  id_q  [NUM_MST_IDS];
  txn_cnt_t cnt_q [NUM_MST_IDS];

  logic                   match_hit;
  mst_id_t                match_idx;
  logic                   free_hit;
  mst_id_t                free_idx;
  logic [NUM_MST_IDS-1:0] inc;
  logic [NUM_MST_IDS-1:0] dec;

  // An entry takes part in the compare only while it has transactions in flight
  always_comb begin
    match_hit = 1'b0;
    match_idx = '0;
    for (int i = 0; i < NUM_MST_IDS; i++) begin
      if ((cnt_q[i] != '0) && (id_q[i] == lookup_id_i)) begin
        match_hit = 1'b1;
        match_idx = mst_id_t'(i);
      end
    end
  end

  // Walk downwards so the lowest free entry is the one left standing
  always_comb begin
    free_hit = 1'b0;
    free_idx = '0;
    for (int i = NUM_MST_IDS - 1; i >= 0; i--) begin
      if (cnt_q[i] == '0) begin
        free_hit = 1'b1;
        free_idx = mst_id_t'(i);
      end
    end
  end

  assign match_o      = match_hit;
  assign match_idx_o  = match_idx;
  assign match_full_o = match_hit && (cnt_q[match_idx] == txn_cnt_t'(MAX_TXNS_PER_ID));
  assign free_o       = free_hit;
  assign free_idx_o   = free_idx;

  // Responses carry the master ID, which names the entry to read back
  assign orig_id_o = id_q[release_idx_i];

  // One-hot strobes per entry for this cycle's allocate and release
  always_comb begin
    inc = '0;
    dec = '0;
    if (alloc_i) begin
      inc[alloc_idx_i] = 1'b1;
    end
    if (release_i) begin
      dec[release_idx_i] = 1'b1;
    end
  end

  // An allocate and a release on the same entry cancel out
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_MST_IDS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_MST_IDS; i++) begin
        if (inc[i] && !dec[i]) begin
          cnt_q[i] <= cnt_q[i] + txn_cnt_t'(1);
        end else if (dec[i] && !inc[i]) begin
          cnt_q[i] <= cnt_q[i] - txn_cnt_t'(1);
        end
      end
    end
  end

  // Rewriting a matched entry stores the ID it already holds
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      id_q[alloc_idx_i] <= lookup_id_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/id_remap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module id_remap_ctrl (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               ar_valid_i,
  input  logic               aw_valid_i,
  input  logic               rd_match_i,
  input  iw_pkg::mst_id_t    rd_match_idx_i,
  input  logic               rd_match_full_i,
  input  logic               rd_free_i,
  input  iw_pkg::mst_id_t    rd_free_idx_i,
  input  logic               wr_match_i,
  input  iw_pkg::mst_id_t    wr_match_idx_i,
  input  logic               wr_match_full_i,
  input  logic               wr_free_i,
  input  iw_pkg::mst_id_t    wr_free_idx_i,
  input  logic               mst_ar_ready_i,
  input  logic               mst_aw_ready_i,
  output logic               slv_ar_ready_o,
  output logic               slv_aw_ready_o,
  output logic               mst_ar_valid_o,
  output logic               mst_aw_valid_o,
  output iw_pkg::mst_id_t    ar_mst_id_o,
  output iw_pkg::mst_id_t    aw_mst_id_o,
  output logic               rd_alloc_o,
  output iw_pkg::mst_id_t    rd_alloc_idx_o,
  output logic               wr_alloc_o,
  output iw_pkg::mst_id_t    wr_alloc_idx_o,
  input  logic               r_last_hs_i,
  input  logic               b_hs_i,
  output logic               rd_release_o,
  output logic               wr_release_o,
  output iw_pkg::stall_cnt_t rd_stall_cnt_o,
  output iw_pkg::stall_cnt_t wr_stall_cnt_o
);

  import iw_pkg::*;

  logic       ar_grant;
  logic       aw_grant;
  mst_id_t    ar_id;
  mst_id_t    aw_id;
  stall_cnt_t rd_stall_q;
  stall_cnt_t wr_stall_q;

  // A known ID may only join its own entry, and only while that entry has room
  // A new ID needs some entry to be free
  assign ar_grant = rd_match_i ? !rd_match_full_i : rd_free_i;
  assign aw_grant = wr_match_i ? !wr_match_full_i : wr_free_i;

  // The matching entry wins over the lowest free one
  assign ar_id = rd_match_i ? rd_match_idx_i : rd_free_idx_i;
  assign aw_id = wr_match_i ? wr_match_idx_i : wr_free_idx_i;

  assign ar_mst_id_o = ar_id;
  assign aw_mst_id_o = aw_id;

  // A stalled request stays hidden from the master and sees ready low
  assign mst_ar_valid_o = ar_valid_i && ar_grant;
  assign mst_aw_valid_o = aw_valid_i && aw_grant;
  assign slv_ar_ready_o = mst_ar_ready_i && ar_grant;
  assign slv_aw_ready_o = mst_aw_ready_i && aw_grant;

  // Entries are claimed on the address handshake itself
  assign rd_alloc_o     = ar_valid_i && ar_grant && mst_ar_ready_i;
  assign wr_alloc_o     = aw_valid_i && aw_grant && mst_aw_ready_i;
  assign rd_alloc_idx_o = ar_id;
  assign wr_alloc_idx_o = aw_id;

  // A read ends with its last R beat, a write with its B response
  assign rd_release_o = r_last_hs_i;
  assign wr_release_o = b_hs_i;

  // Saturating count of cycles a valid request was held back by the table
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_stall_q <= '0;
      wr_stall_q <= '0;
    end else begin
      if (ar_valid_i && !ar_grant && (rd_stall_q != '1)) begin
        rd_stall_q <= rd_stall_q + stall_cnt_t'(1);
      end
      if (aw_valid_i && !aw_grant && (wr_stall_q != '1)) begin
        wr_stall_q <= wr_stall_q + stall_cnt_t'(1);
      end
    end
  end

  assign rd_stall_cnt_o = rd_stall_q;
  assign wr_stall_cnt_o = wr_stall_q;

endmodule

`default_nettype wire

// File: hdl/axi_iw_converter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_iw_converter (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  iw_pkg::slv_req_t slv_req_i,
  output iw_pkg::slv_rsp_t slv_rsp_o,
  output iw_pkg::mst_req_t mst_req_o,
  input  iw_pkg::mst_rsp_t mst_rsp_i
);

  import iw_pkg::*;

  // Lookup results of the read table
  logic    rd_match;
  mst_id_t rd_match_idx;
  logic    rd_match_full;
  logic    rd_free;
  mst_id_t rd_free_idx;
  slv_id_t rd_orig_id;
  // Lookup results of the write table
  logic    wr_match;
  mst_id_t wr_match_idx;
  logic    wr_match_full;
  logic    wr_free;
  mst_id_t wr_free_idx;
  slv_id_t wr_orig_id;

  logic    slv_ar_ready;
  logic    slv_aw_ready;
  logic    mst_ar_valid;
  logic    mst_aw_valid;
  mst_id_t ar_mst_id;
  mst_id_t aw_mst_id;
  logic    rd_alloc;
  mst_id_t rd_alloc_idx;
  logic    wr_alloc;
  mst_id_t wr_alloc_idx;
  logic    rd_release;
  logic    wr_release;
  logic    r_last_hs;
  logic    b_hs;

  // Completion strobes, seen on the response handshakes
  assign r_last_hs = mst_rsp_i.r_valid && slv_req_i.r_ready && mst_rsp_i.r.last;
  assign b_hs      = mst_rsp_i.b_valid && slv_req_i.b_ready;

  id_remap_table u_rd_table (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .lookup_id_i   (slv_req_i.ar.id),
    .match_o       (rd_match),
    .match_idx_o   (rd_match_idx),
    .match_full_o  (rd_match_full),
    .free_o        (rd_free),
    .free_idx_o    (rd_free_idx),
    .alloc_i       (rd_alloc),
    .alloc_idx_i   (rd_alloc_idx),
    .release_i     (rd_release),
    .release_idx_i (mst_rsp_i.r.id),
    .orig_id_o     (rd_orig_id)
  );

  id_remap_table u_wr_table (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .lookup_id_i   (slv_req_i.aw.id),
    .match_o       (wr_match),
    .match_idx_o   (wr_match_idx),
    .match_full_o  (wr_match_full),
    .free_o        (wr_free),
    .free_idx_o    (wr_free_idx),
    .alloc_i       (wr_alloc),
    .alloc_idx_i   (wr_alloc_idx),
    .release_i     (wr_release),
    .release_idx_i (mst_rsp_i.b.id),
    .orig_id_o     (wr_orig_id)
  );

  // The stall counters are kept for debug and not routed out here
  id_remap_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .ar_valid_i      (slv_req_i.ar_valid),
    .aw_valid_i      (slv_req_i.aw_valid),
    .rd_match_i      (rd_match),
    .rd_match_idx_i  (rd_match_idx),
    .rd_match_full_i (rd_match_full),
    .rd_free_i       (rd_free),
    .rd_free_idx_i   (rd_free_idx),
    .wr_match_i      (wr_match),
    .wr_match_idx_i  (wr_match_idx),
    .wr_match_full_i (wr_match_full),
    .wr_free_i       (wr_free),
    .wr_free_idx_i   (wr_free_idx),
    .mst_ar_ready_i  (mst_rsp_i.ar_ready),
    .mst_aw_ready_i  (mst_rsp_i.aw_ready),
    .slv_ar_ready_o  (slv_ar_ready),
    .slv_aw_ready_o  (slv_aw_ready),
    .mst_ar_valid_o  (mst_ar_valid),
    .mst_aw_valid_o  (mst_aw_valid),
    .ar_mst_id_o     (ar_mst_id),
    .aw_mst_id_o     (aw_mst_id),
    .rd_alloc_o      (rd_alloc),
    .rd_alloc_idx_o  (rd_alloc_idx),
    .wr_alloc_o      (wr_alloc),
    .wr_alloc_idx_o  (wr_alloc_idx),
    .r_last_hs_i     (r_last_hs),
    .b_hs_i          (b_hs),
    .rd_release_o    (rd_release),
    .wr_release_o    (wr_release),
    .rd_stall_cnt_o  (),
    .wr_stall_cnt_o  ()
  );

  // Master side requests carry the remapped IDs, the rest passes straight on
  always_comb begin
    mst_req_o.aw.id   = aw_mst_id;
    mst_req_o.aw.addr = slv_req_i.aw.addr;
    mst_req_o.aw.len  = slv_req_i.aw.len;
    mst_req_o.aw_valid = mst_aw_valid;
    mst_req_o.w       = slv_req_i.w;
    mst_req_o.w_valid = slv_req_i.w_valid;
    mst_req_o.b_ready = slv_req_i.b_ready;
    mst_req_o.ar.id   = ar_mst_id;
    mst_req_o.ar.addr = slv_req_i.ar.addr;
    mst_req_o.ar.len  = slv_req_i.ar.len;
    mst_req_o.ar_valid = mst_ar_valid;
    mst_req_o.r_ready = slv_req_i.r_ready;
  end

  // Responses get back the slave ID stored under their master ID
  always_comb begin
    slv_rsp_o.aw_ready = slv_aw_ready;
    slv_rsp_o.w_ready  = mst_rsp_i.w_ready;
    slv_rsp_o.b.id     = wr_orig_id;
    slv_rsp_o.b.resp   = mst_rsp_i.b.resp;
    slv_rsp_o.b_valid  = mst_rsp_i.b_valid;
    slv_rsp_o.ar_ready = slv_ar_ready;
    slv_rsp_o.r.id     = rd_orig_id;
    slv_rsp_o.r.data   = mst_rsp_i.r.data;
    slv_rsp_o.r.resp   = mst_rsp_i.r.resp;
    slv_rsp_o.r.last   = mst_rsp_i.r.last;
    slv_rsp_o.r_valid  = mst_rsp_i.r_valid;
  end

endmodule

`default_nettype wire

// File: sim/tb_axi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_slave_model (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  iw_pkg::mst_req_t req_i,
  output iw_pkg::mst_rsp_t rsp_o,
  input  logic             rd_release_i,
  input  logic             wr_release_i
);

  import iw_pkg::*;

  // Accepted requests in arrival order, answered strictly in that order
  mst_ax_t ar_q [$];
  mst_id_t aw_q [$];
  // Released requests that still owe their response
  int      rd_credit;
  int      wr_credit;
  // Beat number inside the read at the head of the queue
  int      beat;

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_o <= '0;
      ar_q.delete();
      aw_q.delete();
      rd_credit = 0;
      wr_credit = 0;
      beat      = 0;
    end else begin
      // Address and W channels never push back
      rsp_o.ar_ready <= 1'b1;
      rsp_o.aw_ready <= 1'b1;
      rsp_o.w_ready  <= 1'b1;
      if (rsp_o.r_valid && req_i.r_ready) begin
        if (rsp_o.r.last) begin
          void'(ar_q.pop_front());
          rd_credit = rd_credit - 1;
          beat      = 0;
        end else begin
          beat = beat + 1;
        end
      end
      if (rsp_o.b_valid && req_i.b_ready) begin
        void'(aw_q.pop_front());
        wr_credit = wr_credit - 1;
      end
      if (req_i.ar_valid && rsp_o.ar_ready) begin
        ar_q.push_back(req_i.ar);
      end
      if (req_i.aw_valid && rsp_o.aw_ready) begin
        aw_q.push_back(req_i.aw.id);
      end
      // A release only counts for a request that is still waiting
      if (rd_release_i && (rd_credit < ar_q.size())) begin
        rd_credit = rd_credit + 1;
      end
      if (wr_release_i && (wr_credit < aw_q.size())) begin
        wr_credit = wr_credit + 1;
      end
      // Read data is the request address plus the beat number
      if (rd_credit > 0) begin
        rsp_o.r_valid <= 1'b1;
        rsp_o.r.id    <= ar_q[0].id;
        rsp_o.r.data  <= data_t'(ar_q[0].addr) + data_t'(beat);
        rsp_o.r.resp  <= 2'b00;
        rsp_o.r.last  <= (beat == int'(ar_q[0].len));
      end else begin
        rsp_o.r_valid <= 1'b0;
      end
      if (wr_credit > 0) begin
        rsp_o.b_valid <= 1'b1;
        rsp_o.b.id    <= aw_q[0];
        rsp_o.b.resp  <= 2'b00;
      end else begin
        rsp_o.b_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_axi_iw_converter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_iw_converter;

  import iw_pkg::*;

  localparam int unsigned NUM_RAND_RD = 24;
  localparam int unsigned NUM_RAND_WR = 16;
  // Two directed stall tests add five reads each
  localparam int unsigned NUM_TXNS    = NUM_RAND_RD + NUM_RAND_WR + 10;
  localparam int unsigned SEED        = 32'h6aad_73f5;

  logic     clk = 1'b0;
  logic     rst_n;
  slv_req_t slv_req;
  slv_rsp_t slv_rsp;
  mst_req_t mst_req;
  mst_rsp_t mst_rsp;
  logic     rd_release;
  logic     wr_release;
  logic     rand_done;

  // Requests accepted at the slave port, oldest first
  slv_ax_t rd_exp [$];
  slv_id_t wr_exp [$];
  int      rd_beat;
  // Own copy of both remap tables, kept from the handshakes
  slv_id_t rd_owner [NUM_MST_IDS];
  int      rd_cnt   [NUM_MST_IDS];
  slv_id_t wr_owner [NUM_MST_IDS];
  int      wr_cnt   [NUM_MST_IDS];

  axi_iw_converter u_axi_iw_converter (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .slv_req_i (slv_req),
    .slv_rsp_o (slv_rsp),
    .mst_req_o (mst_req),
    .mst_rsp_i (mst_rsp)
  );

  tb_axi_slave_model u_slave (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_i        (mst_req),
    .rsp_o        (mst_rsp),
    .rd_release_i (rd_release),
    .wr_release_i (wr_release)
  );

  always #4 clk = ~clk;

  // Expected R beat of a request, data is the address plus the beat number
  function automatic slv_r_t expected_beat(input slv_ax_t req, input int beat);
    slv_r_t r;
    r.id   = req.id;
    r.data = data_t'(req.addr) + data_t'(beat);
    r.resp = 2'b00;
    r.last = (beat == int'(req.len));
    return r;
  endfunction

  // Returns the grant and the master ID, an in-flight ID keeps its entry
  // while a new ID takes the lowest free one
  function automatic logic [MST_ID_W:0] expected_remap(input slv_id_t id,
      input slv_id_t owner [NUM_MST_IDS], input int cnt [NUM_MST_IDS]);
    logic [MST_ID_W:0] res;
    res = '0;
    for (int i = NUM_MST_IDS - 1; i >= 0; i--) begin
      if (cnt[i] == 0) begin
        res = {1'b1, mst_id_t'(i)};
      end
    end
    for (int i = 0; i < NUM_MST_IDS; i++) begin
      if ((cnt[i] != 0) && (owner[i] == id)) begin
        res = {(cnt[i] < int'(MAX_TXNS_PER_ID)), mst_id_t'(i)};
      end
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp_val,
      input logic [63:0] act_val);
    assert (act_val === exp_val) else begin
      $display("MISMATCH %s: expected %0h, actual %0h", name, exp_val, act_val);
      $display("test failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("ERROR: %s", what);
      $display("test failed");
      $fatal(1, "Stopped at the first error");
    end
  endtask

  // Checks every handshake against the own table copy and the recorded requests
  always @(posedge clk) begin : compare
    logic [MST_ID_W:0] rd_ref;
    logic [MST_ID_W:0] wr_ref;
    if (!rst_n) begin
      rd_beat = 0;
      for (int i = 0; i < NUM_MST_IDS; i++) begin
        rd_cnt[i]   = 0;
        wr_cnt[i]   = 0;
        rd_owner[i] = '0;
        wr_owner[i] = '0;
      end
    end else begin
      rd_ref = expected_remap(slv_req.ar.id, rd_owner, rd_cnt);
      wr_ref = expected_remap(slv_req.aw.id, wr_owner, wr_cnt);
      // A stalled request is hidden from the master and sees ready low
      check_value("ar_valid at master", 64'(slv_req.ar_valid && rd_ref[MST_ID_W]),
                  64'(mst_req.ar_valid));
      check_value("aw_valid at master", 64'(slv_req.aw_valid && wr_ref[MST_ID_W]),
                  64'(mst_req.aw_valid));
      if (slv_req.ar_valid) begin
        check_value("ar_ready", 64'(rd_ref[MST_ID_W] && mst_rsp.ar_ready),
                    64'(slv_rsp.ar_ready));
      end
      if (slv_req.aw_valid) begin
        check_value("aw_ready", 64'(wr_ref[MST_ID_W] && mst_rsp.aw_ready),
                    64'(slv_rsp.aw_ready));
      end
      if (slv_req.ar_valid && slv_rsp.ar_ready) begin
        check_value("ar master ID", 64'(rd_ref[MST_ID_W-1:0]), 64'(mst_req.ar.id));
        rd_exp.push_back(slv_req.ar);
        rd_owner[rd_ref[MST_ID_W-1:0]] = slv_req.ar.id;
        rd_cnt[rd_ref[MST_ID_W-1:0]]   = rd_cnt[rd_ref[MST_ID_W-1:0]] + 1;
      end
      if (slv_req.aw_valid && slv_rsp.aw_ready) begin
        check_value("aw master ID", 64'(wr_ref[MST_ID_W-1:0]), 64'(mst_req.aw.id));
        // Address and length reach the master port untouched
        check_value("aw addr and len", 64'({slv_req.aw.addr, slv_req.aw.len}),
                    64'({mst_req.aw.addr, mst_req.aw.len}));
        wr_exp.push_back(slv_req.aw.id);
        wr_owner[wr_ref[MST_ID_W-1:0]] = slv_req.aw.id;
        wr_cnt[wr_ref[MST_ID_W-1:0]]   = wr_cnt[wr_ref[MST_ID_W-1:0]] + 1;
      end
      if (slv_rsp.r_valid && slv_req.r_ready) begin
        check_true(rd_exp.size() > 0, "R beat arrived with no read outstanding");
        check_value("read beat", 64'(expected_beat(rd_exp[0], rd_beat)), 64'(slv_rsp.r));
        if (slv_rsp.r.last) begin
          void'(rd_exp.pop_front());
          rd_beat = 0;
          rd_cnt[mst_rsp.r.id] = rd_cnt[mst_rsp.r.id] - 1;
        end else begin
          rd_beat = rd_beat + 1;
        end
      end
      if (slv_rsp.b_valid && slv_req.b_ready) begin
        check_true(wr_exp.size() > 0, "B response arrived with no write outstanding");
        check_value("write response", 64'({wr_exp[0], 2'b00}), 64'(slv_rsp.b));
        void'(wr_exp.pop_front());
        wr_cnt[mst_rsp.b.id] = wr_cnt[mst_rsp.b.id] - 1;
      end
      // W and the response ready lines leave the master port exactly as they were sent
      check_value("w_valid at master", 64'(slv_req.w_valid), 64'(mst_req.w_valid));
      check_value("ready lines at master", 64'({slv_req.r_ready, slv_req.b_ready}),
                  64'({mst_req.r_ready, mst_req.b_ready}));
      if (slv_req.w_valid) begin
        check_value("write beat", 64'(slv_req.w), 64'(mst_req.w));
      end
    end
  end

  // Drives one AR and returns once the slave port accepts it
  task automatic send_read(input slv_id_t id, input addr_t addr, input len_t len);
    slv_req.ar.id    = id;
    slv_req.ar.addr  = addr;
    slv_req.ar.len   = len;
    slv_req.ar_valid = 1'b1;
    do begin
      @(posedge clk);
    end while (!slv_rsp.ar_ready);
    #1;
    slv_req.ar_valid = 1'b0;
  endtask

  // Drives one AW and then its len+1 W beats with random data and strobes
  task automatic send_write(input slv_id_t id, input addr_t addr, input len_t len);
    w_chan_t w;
    slv_req.aw.id    = id;
    slv_req.aw.addr  = addr;
    slv_req.aw.len   = len;
    slv_req.aw_valid = 1'b1;
    do begin
      @(posedge clk);
    end while (!slv_rsp.aw_ready);
    #1;
    slv_req.aw_valid = 1'b0;
    for (int b = 0; b <= int'(len); b++) begin
      w.data          = $urandom;
      w.strb          = strb_t'($urandom);
      w.last          = (b == int'(len));
      slv_req.w       = w;
      slv_req.w_valid = 1'b1;
      do begin
        @(posedge clk);
      end while (!slv_rsp.w_ready);
      #1;
    end
    slv_req.w_valid = 1'b0;
  endtask

  // Lets the slave model answer the next n reads
  task automatic release_reads(input int n);
    rd_release = 1'b1;
    repeat (n) @(posedge clk);
    #1;
    rd_release = 1'b0;
  endtask

  // Holds a read that has to stall, then frees one read so it gets in
  task automatic stalled_read(input slv_id_t id, input string what);
    slv_req.ar.id    = id;
    slv_req.ar.addr  = addr_t'($urandom);
    slv_req.ar.len   = '0;
    slv_req.ar_valid = 1'b1;
    repeat (6) begin
      @(posedge clk);
      check_true(!slv_rsp.ar_ready, what);
    end
    #1;
    rd_release = 1'b1;
    @(posedge clk);
    check_true(!slv_rsp.ar_ready, what);
    #1;
    rd_release = 1'b0;
    do begin
      @(posedge clk);
    end while (!slv_rsp.ar_ready);
    #1;
    slv_req.ar_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while ((rd_exp.size() != 0) || (wr_exp.size() != 0)) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    slv_req    = '0;
    rd_release = 1'b0;
    wr_release = 1'b0;
    rand_done  = 1'b0;
    slv_req.r_ready = 1'b1;
    slv_req.b_ready = 1'b1;
    void'($urandom(SEED));
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    check_true(!mst_req.ar_valid && !mst_req.aw_valid,
               "master valid high after reset with no request driven");
    #1;
    // Four distinct IDs fill the read table and a fifth new ID has to wait
    for (int i = 0; i < 4; i++) begin
      send_read(slv_id_t'(6'h10 + i), addr_t'($urandom), len_t'($urandom_range(0, 3)));
    end
    stalled_read(6'h20, "fifth new read ID accepted while every entry was busy");
    release_reads(4);
    wait_idle();
    // Four reads of one ID fill its entry to the cap
    for (int i = 0; i < 4; i++) begin
      send_read(6'h2a, addr_t'($urandom), len_t'($urandom_range(0, 3)));
    end
    stalled_read(6'h2a, "fifth read of one ID accepted while its entry was full");
    release_reads(4);
    wait_idle();
    // Random reads over six IDs, so IDs get shared and the table runs full
    fork
      begin
        for (int i = 0; i < NUM_RAND_RD; i++) begin
          send_read(slv_id_t'(6'h30 + $urandom_range(0, 5)), addr_t'($urandom),
                    len_t'($urandom_range(0, 3)));
        end
        rand_done = 1'b1;
      end
      begin
        while (!rand_done || (rd_exp.size() != 0)) begin
          @(posedge clk);
          #1;
          rd_release = ($urandom_range(0, 2) == 0);
        end
        rd_release = 1'b0;
      end
    join
    rand_done = 1'b0;
    // Random writes in the same way, B answers come at random times
    fork
      begin
        for (int i = 0; i < NUM_RAND_WR; i++) begin
          send_write(slv_id_t'(6'h08 + $urandom_range(0, 5)), addr_t'($urandom),
                     len_t'($urandom_range(0, 3)));
        end
        rand_done = 1'b1;
      end
      begin
        while (!rand_done || (wr_exp.size() != 0)) begin
          @(posedge clk);
          #1;
          wr_release = ($urandom_range(0, 2) == 0);
        end
        wr_release = 1'b0;
      end
    join
    wait_idle();
    repeat (2) @(posedge clk);
    $display("test passed");
    $finish;
  end

  // Generous bound of 200 cycles for every transaction of the run
  initial begin
    repeat (NUM_TXNS * 200) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, the run is stuck", NUM_TXNS * 200);
    $display("test failed");
    $fatal(1, "Watchdog timeout");
  end

endmodule

`default_nettype wire

// File: axi_iw_converter.f
hdl/iw_pkg.sv
hdl/id_remap_table.sv
hdl/id_remap_ctrl.sv
hdl/axi_iw_converter.sv
sim/tb_axi_slave_model.sv
sim/tb_axi_iw_converter.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_axi_iw_converter \
  -f axi_iw_converter.f -o tb_axi_iw_converter > compile.log 2>&1 \
  || { echo "Build failed, see compile.log"; exit 1; }
./obj_dir/tb_axi_iw_converter > sim.log 2>&1
grep -q "test failed" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
echo "Simulation passed, see sim.log"
exit 0
